//--- sim.f
chip_pkg.sv
supply_sim.sv
pok_filter.sv
por_stretch.sv
pad_map.sv
chip_shell.sv
tb_chip_shell.sv

//--- run.sh
#!/bin/sh
# build and run the chip shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_chip_shell -f sim.f -o tb_chip_shell

./obj_dir/tb_chip_shell > sim.log 2>&1 || true
cat sim.log

if grep -q "PASS: all tests" sim.log; then
  exit 0
fi
exit 1

//--- tb_chip_shell.sv
//////////////////////////////////////////////////
// testbench drives the core pad side directly
// aon release edge is derived from the supply pattern
//////////////////////////////////////////////////
`default_nettype none

module tb_chip_shell
  import chip_pkg::*;
#(
  parameter int SupplyStep  = 4,
  parameter int PokDebounce = 6,
  parameter int ResetHold   = 3
);

  // final high phase starts at count 3*step, seen one edge later
  localparam int ExpAonRise = 3 * SupplyStep + PokDebounce + ResetHold;
  localparam int WaitLimit  = 200;
  localparam int NRand      = 50;

  logic                 clk_aon;
  logic                 arst_n;
  logic                 vmain_supp;
  logic [NDomains-1:0]  por_n;
  core_pads_t           core;
  logic [NMioPads-1:0]  mio_in;
  logic [NDioPads-1:0]  dio_in;
  logic [GpioWidth-1:0] gpio_p2d;
  gpio_pins_t           gpio;
  logic uart_rx, uart_tx, uart_tx_en;
  logic spi_sck, spi_csb, spi_sdi, spi_sdo, spi_sdo_en;
  logic usb_dp, usb_dn, usb_dp_out, usb_dp_en, usb_dn_out, usb_dn_en;

  logic [31:0] rng_state;
  int          edge_cnt;
  int          errors;
  int          checks;

  chip_shell #(
    .SupplyStep  (SupplyStep),
    .PokDebounce (PokDebounce),
    .ResetHold   (ResetHold)
  ) UUT (
    .clk_aon (clk_aon), .arst_n_i (arst_n), .vmain_supp_i (vmain_supp), .por_n_o (por_n),
    .core_i (core), .mio_in_o (mio_in), .dio_in_o (dio_in),
    .gpio_p2d_i (gpio_p2d), .gpio_o (gpio),
    .uart_rx_i (uart_rx), .uart_tx_o (uart_tx), .uart_tx_en_o (uart_tx_en),
    .spi_sck_i (spi_sck), .spi_csb_i (spi_csb), .spi_sdi_i (spi_sdi),
    .spi_sdo_o (spi_sdo), .spi_sdo_en_o (spi_sdo_en),
    .usb_dp_i (usb_dp), .usb_dn_i (usb_dn), .usb_dp_o (usb_dp_out),
    .usb_dp_en_o (usb_dp_en), .usb_dn_o (usb_dn_out), .usb_dn_en_o (usb_dn_en)
  );

  always #50 clk_aon = ~clk_aon;

  // posedges since reset release
  always @(posedge clk_aon or negedge arst_n) begin
    if (!arst_n) begin
      edge_cnt <= 0;
    end else begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  //////////////////////////////////////////////////
  // concurrent checks
  //////////////////////////////////////////////////

  a_en_held : assert property (@(negedge clk_aon) disable iff (!arst_n)
    !por_n[DomAon] |-> (gpio.en == '0) && (gpio.pull_en == '0) &&
      !uart_tx_en && !spi_sdo_en && !usb_dp_en && !usb_dn_en)
    else begin
      $display("[FAIL] %0t: a pin enable is active while aon por_n is low", $time);
      errors++;
    end

  a_aon_once : assert property (@(posedge clk_aon) disable iff (!arst_n)
    !$fell(por_n[DomAon]))
    else begin
      $display("[FAIL] %0t: aon por_n dropped after its release", $time);
      errors++;
    end

  a_main_in_aon : assert property (@(posedge clk_aon) disable iff (!arst_n)
    por_n[DomMain] |-> por_n[DomAon])
    else begin
      $display("[FAIL] %0t: main por_n released while aon is in reset", $time);
      errors++;
    end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // pin bit per mio pad, -1 when the pad has no GPIO pin
  function automatic int pin_bit_of_pad(int p);
    if (p < 14) return p;
    if (p < 17) return 22 + (p - 14);
    if (p == 17) return 27;
    if (p == 18) return 30;
    return -1;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] got_v);
    checks++;
    assert (got_v === exp_v)
      else begin
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, got_v);
        errors++;
      end
  endtask

  task automatic drive_random_core();
    logic [31:0] r0, r1, r2;
    r0 = next_rand();
    r1 = next_rand();
    r2 = next_rand();
    core = core_pads_t'({r0, r1, r2});
  endtask

  task automatic check_out_pins();
    logic [31:0] e_d2p, e_en, e_pe, e_ps;
    int b;
    e_d2p = '0;
    e_en  = '0;
    e_pe  = '0;
    e_ps  = '0;
    for (int p = 0; p < NMioPads; p++) begin
      b = pin_bit_of_pad(p);
      if (b >= 0) begin
        e_d2p[b] = core.mio_out[p];
        e_en[b]  = core.mio_oe[p];
        e_pe[b]  = core.mio_attr[p].pull_en;
        e_ps[b]  = core.mio_attr[p].pull_select;
      end
    end
    check_val("gpio_o.d2p", e_d2p, gpio.d2p);
    check_val("gpio_o.en", e_en, gpio.en);
    check_val("gpio_o.pull_en", e_pe, gpio.pull_en);
    check_val("gpio_o.pull_select", e_ps, gpio.pull_select);
    check_val("uart_tx", 32'({core.mio_out[MioUartTx], core.mio_oe[MioUartTx]}),
              32'({uart_tx, uart_tx_en}));
    check_val("spi_sdo", 32'({core.dio_out[DioSpiSdo], core.dio_oe[DioSpiSdo]}),
              32'({spi_sdo, spi_sdo_en}));
    check_val("usb_dp", 32'({core.dio_out[DioUsbDp], core.dio_oe[DioUsbDp]}),
              32'({usb_dp_out, usb_dp_en}));
    check_val("usb_dn", 32'({core.dio_out[DioUsbDn], core.dio_oe[DioUsbDn]}),
              32'({usb_dn_out, usb_dn_en}));
  endtask

  task automatic check_in_pads();
    logic [NMioPads-1:0] e_mio;
    logic [NDioPads-1:0] e_dio;
    int b;
    e_mio = '0;
    for (int p = 0; p < NMioPads; p++) begin
      b = pin_bit_of_pad(p);
      if (b >= 0) begin
        e_mio[p] = gpio_p2d[b];
      end
    end
    e_mio[MioUartRx] = uart_rx;
    // sdo has no input path
    e_dio = {usb_dn, usb_dp, 1'b0, spi_sdi, spi_csb, spi_sck};
    check_val("mio_in_o", 32'(e_mio), 32'(mio_in));
    check_val("dio_in_o", 32'(e_dio), 32'(dio_in));
  endtask

  task automatic report_test(input string name, input int base);
    $display("test %s: %0d errors", name, errors - base);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    int base;
    int rise_edge;
    int wait_n;
    logic [31:0] r;
    clk_aon    = 1'b0;
    arst_n     = 1'b0;
    vmain_supp = 1'b0;
    core       = '0;
    gpio_p2d   = '0;
    uart_rx    = 1'b0;
    spi_sck    = 1'b0;
    spi_csb    = 1'b0;
    spi_sdi    = 1'b0;
    usb_dp     = 1'b0;
    usb_dn     = 1'b0;
    rng_state  = 32'd38;
    errors     = 0;
    checks     = 0;
    repeat (4) @(negedge clk_aon);
    arst_n = 1'b1;

    // reset state and glitch filtering share one wait
    base      = errors;
    rise_edge = -1;
    wait_n    = 0;
    while (rise_edge < 0 && wait_n < WaitLimit) begin
      @(negedge clk_aon);
      if (por_n[DomAon]) begin
        rise_edge = edge_cnt;
      end else begin
        check_val("por_n_o", '0, 32'(por_n));
        check_val("gpio_o.en", '0, gpio.en);
        check_val("pad enables", '0, 32'({uart_tx_en, spi_sdo_en, usb_dp_en, usb_dn_en}));
      end
      drive_random_core();
      wait_n++;
    end
    report_test("1 reset state", base);
    base = errors;
    if (rise_edge < 0) begin
      $display("[FAIL] %0t: timeout waiting for aon por_n to rise", $time);
      errors++;
    end else begin
      check_val("aon por_n rise edge", ExpAonRise, rise_edge);
    end
    report_test("2 glitch filter", base);

    // main domain follows vmain_supp
    base = errors;
    repeat (20) begin
      @(negedge clk_aon);
      check_val("por_n_o", 32'b01, 32'(por_n));
    end
    vmain_supp = 1'b1;
    wait_n     = 0;
    while (!por_n[DomMain] && wait_n < WaitLimit) begin
      @(negedge clk_aon);
      wait_n++;
    end
    if (!por_n[DomMain]) begin
      $display("[FAIL] %0t: timeout waiting for main por_n to rise", $time);
      errors++;
    end
    vmain_supp = 1'b0;
    repeat (2) @(negedge clk_aon);
    check_val("por_n_o", 32'b01, 32'(por_n));
    report_test("3 main domain", base);

    base = errors;
    repeat (NRand) begin
      drive_random_core();
      @(negedge clk_aon);
      check_out_pins();
    end
    report_test("4 output mapping", base);

    base = errors;
    repeat (NRand) begin
      gpio_p2d = next_rand();
      r        = next_rand();
      uart_rx  = r[0];
      spi_sck  = r[1];
      spi_csb  = r[2];
      spi_sdi  = r[3];
      usb_dp   = r[4];
      usb_dn   = r[5];
      @(negedge clk_aon);
      check_in_pads();
    end
    report_test("5 input mapping", base);

    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_chip_shell

`default_nettype wire

//--- chip_shell.sv
//////////////////////////////////////////////////
// chip shell around an external core model
// clk_aon comes straight from the platform
//////////////////////////////////////////////////
`default_nettype none

module chip_shell
  import chip_pkg::*;
#(
  parameter int SupplyStep  = DefSupplyStep,
  parameter int PokDebounce = DefPokDebounce,
  parameter int ResetHold   = DefResetHold
) (
  input  wire                  clk_aon,
  input  wire                  arst_n_i,
  input  wire                  vmain_supp_i,
  output logic [NDomains-1:0]  por_n_o,
  input  core_pads_t           core_i,
  output logic [NMioPads-1:0]  mio_in_o,
  output logic [NDioPads-1:0]  dio_in_o,
  input  wire  [GpioWidth-1:0] gpio_p2d_i,
  output gpio_pins_t           gpio_o,
  input  wire                  uart_rx_i,
  output logic                 uart_tx_o,
  output logic                 uart_tx_en_o,
  input  wire                  spi_sck_i,
  input  wire                  spi_csb_i,
  input  wire                  spi_sdi_i,
  output logic                 spi_sdo_o,
  output logic                 spi_sdo_en_o,
  input  wire                  usb_dp_i,
  input  wire                  usb_dn_i,
  output logic                 usb_dp_o,
  output logic                 usb_dp_en_o,
  output logic                 usb_dn_o,
  output logic                 usb_dn_en_o
);

  logic                vcc_supp;
  logic [NDomains-1:0] pok;

  //////////////////////////////////////////////////
  // power and reset
  //////////////////////////////////////////////////

  supply_sim #(
    .SupplyStep (SupplyStep)
  ) u_supply_sim (
    .clk_aon    (clk_aon),
    .arst_n_i   (arst_n_i),
    .vcc_supp_o (vcc_supp)
  );

  pok_filter #(
    .PokDebounce (PokDebounce)
  ) u_pok_filter (
    .clk_aon      (clk_aon),
    .arst_n_i     (arst_n_i),
    .vcc_supp_i   (vcc_supp),
    .vmain_supp_i (vmain_supp_i),
    .pok_o        (pok)
  );

  por_stretch #(
    .ResetHold (ResetHold)
  ) u_por_stretch (
    .clk_aon  (clk_aon),
    .arst_n_i (arst_n_i),
    .pok_i    (pok),
    .por_n_o  (por_n_o)
  );

  //////////////////////////////////////////////////
  // pads
  //////////////////////////////////////////////////

  pad_map u_pad_map (
    .aon_rst_n_i  (por_n_o[DomAon]),
    .core_i       (core_i),
    .mio_in_o     (mio_in_o),
    .dio_in_o     (dio_in_o),
    .gpio_p2d_i   (gpio_p2d_i),
    .gpio_o       (gpio_o),
    .uart_rx_i    (uart_rx_i),
    .uart_tx_o    (uart_tx_o),
    .uart_tx_en_o (uart_tx_en_o),
    .spi_sck_i    (spi_sck_i),
    .spi_csb_i    (spi_csb_i),
    .spi_sdi_i    (spi_sdi_i),
    .spi_sdo_o    (spi_sdo_o),
    .spi_sdo_en_o (spi_sdo_en_o),
    .usb_dp_i     (usb_dp_i),
    .usb_dn_i     (usb_dn_i),
    .usb_dp_o     (usb_dp_o),
    .usb_dp_en_o  (usb_dp_en_o),
    .usb_dn_o     (usb_dn_o),
    .usb_dn_en_o  (usb_dn_en_o)
  );

endmodule : chip_shell

`default_nettype wire

//--- pad_map.sv
//////////////////////////////////////////////////
// core pad vectors to chip pins, purely combinational
// enables held low while the aon domain is in reset
//////////////////////////////////////////////////
`default_nettype none

module pad_map
  import chip_pkg::*;
(
  input  wire                  aon_rst_n_i,
  input  core_pads_t           core_i,
  output logic [NMioPads-1:0]  mio_in_o,
  output logic [NDioPads-1:0]  dio_in_o,
  input  wire  [GpioWidth-1:0] gpio_p2d_i,
  output gpio_pins_t           gpio_o,
  input  wire                  uart_rx_i,
  output logic                 uart_tx_o,
  output logic                 uart_tx_en_o,
  input  wire                  spi_sck_i,
  input  wire                  spi_csb_i,
  input  wire                  spi_sdi_i,
  output logic                 spi_sdo_o,
  output logic                 spi_sdo_en_o,
  input  wire                  usb_dp_i,
  input  wire                  usb_dn_i,
  output logic                 usb_dp_o,
  output logic                 usb_dp_en_o,
  output logic                 usb_dn_o,
  output logic                 usb_dn_en_o
);

  // reverse lookup, pin bit to pad index
  function automatic int pad_of_bit(int b);
    int pad;
    pad = NoGpio;
    for (int p = 0; p < NMioPads; p++) begin
      if (GpioBitOf[p] == b) begin
        pad = p;
      end
    end
    return pad;
  endfunction

  function automatic logic [GpioWidth-1:0] mapped_mask();
    logic [GpioWidth-1:0] mask;
    mask = '0;
    for (int p = 0; p < NMioPads; p++) begin
      if (GpioBitOf[p] != NoGpio) begin
        mask[GpioBitOf[p]] = 1'b1;
      end
    end
    return mask;
  endfunction

  localparam logic [GpioWidth-1:0] MappedMask = mapped_mask();

  logic [GpioWidth-1:0] gpio_d2p;
  logic [GpioWidth-1:0] gpio_en;
  logic [GpioWidth-1:0] gpio_pull_en;
  logic [GpioWidth-1:0] gpio_pull_sel;

  //////////////////////////////////////////////////
  // pad to pin
  //////////////////////////////////////////////////

  for (genvar b = 0; b < GpioWidth; b++) begin : g_gpio_out
    localparam int Pad = pad_of_bit(b);
    if (Pad != NoGpio) begin : g_map
      assign gpio_d2p[b]      = core_i.mio_out[Pad];
      assign gpio_en[b]       = core_i.mio_oe[Pad] & aon_rst_n_i;
      assign gpio_pull_en[b]  = core_i.mio_attr[Pad].pull_en & aon_rst_n_i;
      assign gpio_pull_sel[b] = core_i.mio_attr[Pad].pull_select;
    end else begin : g_tie
      assign gpio_d2p[b]      = 1'b0;
      assign gpio_en[b]       = 1'b0;
      assign gpio_pull_en[b]  = 1'b0;
      assign gpio_pull_sel[b] = 1'b0;
    end
  end

  assign gpio_o = '{d2p: gpio_d2p, en: gpio_en, pull_en: gpio_pull_en,
                    pull_select: gpio_pull_sel};

  assign uart_tx_o    = core_i.mio_out[MioUartTx];
  assign uart_tx_en_o = core_i.mio_oe[MioUartTx] & aon_rst_n_i;
  assign spi_sdo_o    = core_i.dio_out[DioSpiSdo];
  assign spi_sdo_en_o = core_i.dio_oe[DioSpiSdo] & aon_rst_n_i;
  assign usb_dp_o     = core_i.dio_out[DioUsbDp];
  assign usb_dp_en_o  = core_i.dio_oe[DioUsbDp] & aon_rst_n_i;
  assign usb_dn_o     = core_i.dio_out[DioUsbDn];
  assign usb_dn_en_o  = core_i.dio_oe[DioUsbDn] & aon_rst_n_i;

  //////////////////////////////////////////////////
  // pin to pad
  //////////////////////////////////////////////////

  for (genvar p = 0; p < NMioPads; p++) begin : g_mio_in
    if (GpioBitOf[p] != NoGpio) begin : g_gpio
      assign mio_in_o[p] = gpio_p2d_i[GpioBitOf[p]];
    end else if (p == int'(MioUartRx)) begin : g_uart
      assign mio_in_o[p] = uart_rx_i;
    end else begin : g_tie
      assign mio_in_o[p] = 1'b0;
    end
  end

  // sdo is output only, its input stays 0
  always_comb begin
    dio_in_o            = '0;
    dio_in_o[DioSpiSck] = spi_sck_i;
    dio_in_o[DioSpiCsb] = spi_csb_i;
    dio_in_o[DioSpiSdi] = spi_sdi_i;
    dio_in_o[DioUsbDp]  = usb_dp_i;
    dio_in_o[DioUsbDn]  = usb_dn_i;
  end

  // pins outside the table never drive
  always_comb begin
    a_unmapped_en : assert ((gpio_o.en & ~MappedMask) == '0)
      else $error("unmapped GPIO enable set: %h", gpio_o.en);
  end

endmodule : pad_map

`default_nettype wire

//--- por_stretch.sv
//////////////////////////////////////////////////
// power-on reset per domain from pok
// release ResetHold cycles after pok, drop 1 later
//////////////////////////////////////////////////
`default_nettype none

module por_stretch
  import chip_pkg::*;
#(
  parameter int ResetHold = DefResetHold
) (
  input  wire                 clk_aon,
  input  wire                 arst_n_i,
  input  wire  [NDomains-1:0] pok_i,
  output logic [NDomains-1:0] por_n_o
);

  localparam int HoldW = $clog2(ResetHold + 1);
  localparam logic [HoldW-1:0] HoldLoad = HoldW'(ResetHold - 1);

  logic [HoldW-1:0] hold_q [NDomains];

  // hold counter reloads while pok is low, counts down once it is high
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      por_n_o <= '0;
      for (int d = 0; d < NDomains; d++) begin
        hold_q[d] <= HoldLoad;
      end
    end else begin
      for (int d = 0; d < NDomains; d++) begin
        if (!pok_i[d]) begin
          hold_q[d]  <= HoldLoad;
          por_n_o[d] <= 1'b0;
        end else if (hold_q[d] != '0) begin
          hold_q[d] <= hold_q[d] - 1'b1;
        end else begin
          por_n_o[d] <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // release only after pok has been up for the whole hold time
  for (genvar d = 0; d < NDomains; d++) begin : g_chk
    a_rise_needs_pok : assert property (@(posedge clk_aon) disable iff (!arst_n_i)
      $rose(por_n_o[d]) |-> pok_i[d] && $past(pok_i[d], ResetHold));
  end

endmodule : por_stretch

`default_nettype wire

//--- pok_filter.sv
//////////////////////////////////////////////////
// power-ok per domain, debounced on the way up
// main domain also needs the vcc supply
//////////////////////////////////////////////////
`default_nettype none

module pok_filter
  import chip_pkg::*;
#(
  parameter int PokDebounce = DefPokDebounce
) (
  input  wire                 clk_aon,
  input  wire                 arst_n_i,
  input  wire                 vcc_supp_i,
  input  wire                 vmain_supp_i,
  output logic [NDomains-1:0] pok_o
);

  localparam int CntW = $clog2(PokDebounce + 1);
  localparam logic [CntW-1:0] CntLast = CntW'(PokDebounce - 1);

  logic [NDomains-1:0] supp;
  logic [CntW-1:0]     cnt_q [NDomains];

  always_comb begin
    supp          = '0;
    supp[DomAon]  = vcc_supp_i;
    supp[DomMain] = vcc_supp_i & vmain_supp_i;
  end

  //////////////////////////////////////////////////
  // debounce counters
  //////////////////////////////////////////////////

  // counts consecutive high edges, a low edge drops pok at once
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pok_o <= '0;
      for (int d = 0; d < NDomains; d++) begin
        cnt_q[d] <= '0;
      end
    end else begin
      for (int d = 0; d < NDomains; d++) begin
        if (!supp[d]) begin
          cnt_q[d] <= '0;
          pok_o[d] <= 1'b0;
        end else if (!pok_o[d]) begin
          if (cnt_q[d] == CntLast) begin
            pok_o[d] <= 1'b1;
          end else begin
            cnt_q[d] <= cnt_q[d] + 1'b1;
          end
        end
      end
    end
  end

  // main is only ever good inside a good aon domain
  a_main_needs_aon : assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    pok_o[DomMain] |-> pok_o[DomAon]);

endmodule : pok_filter

`default_nettype wire

//--- supply_sim.sv
//////////////////////////////////////////////////
// fake supply ramp: low, high, low, then high
// sequence runs once per arst_n_i release
//////////////////////////////////////////////////
`default_nettype none

module supply_sim
  import chip_pkg::*;
#(
  parameter int SupplyStep = DefSupplyStep
) (
  input  wire  clk_aon,
  input  wire  arst_n_i,
  output logic vcc_supp_o
);

  localparam int CntW = $clog2(4 * SupplyStep);
  localparam logic [CntW-1:0] CntMax = CntW'(4 * SupplyStep - 1);

  logic [CntW-1:0] cnt_q;

  // step until saturation, then hold
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_q != CntMax) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // one glitch window before the final high phase
  assign vcc_supp_o = (cnt_q < CntW'(SupplyStep))     ? 1'b0 :
                      (cnt_q < CntW'(2 * SupplyStep)) ? 1'b1 :
                      (cnt_q < CntW'(3 * SupplyStep)) ? 1'b0 : 1'b1;

  // once saturated the supply must stay up
  a_no_wrap : assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    (cnt_q == CntMax) |=> (cnt_q == CntMax) && vcc_supp_o);

endmodule : supply_sim

`default_nettype wire

//--- chip_pkg.sv
//////////////////////////////////////////////////
// pad indices and GPIO bit table for the shell
// pads without a GPIO bit use NoGpio in GpioBitOf
//////////////////////////////////////////////////
`default_nettype none

package chip_pkg;

  localparam int NMioPads  = 21;
  localparam int NDioPads  = 6;
  localparam int NDomains  = 2;
  localparam int GpioWidth = 32;

  // timing defaults, in clk_aon cycles
  localparam int DefSupplyStep  = 4;
  localparam int DefPokDebounce = 6;
  localparam int DefResetHold   = 3;

  typedef enum logic [4:0] {
    MioGpio0, MioGpio1, MioGpio2, MioGpio3, MioGpio4, MioGpio5, MioGpio6,
    MioGpio7, MioGpio8, MioGpio9, MioGpio10, MioGpio11, MioGpio12, MioGpio13,
    MioSwStrap0, MioSwStrap1, MioSwStrap2,
    MioTapStrap0, MioTapStrap1,
    MioUartRx, MioUartTx
  } mio_pad_e;

  typedef enum logic [2:0] {
    DioSpiSck, DioSpiCsb, DioSpiSdi, DioSpiSdo, DioUsbDp, DioUsbDn
  } dio_pad_e;

  typedef enum logic [0:0] {
    DomAon  = 1'b0,
    DomMain = 1'b1
  } domain_e;

  typedef struct packed {
    logic pull_en;
    logic pull_select;
  } pad_attr_t;

  typedef struct packed {
    logic [NMioPads-1:0]            mio_out;
    logic [NMioPads-1:0]            mio_oe;
    pad_attr_t [NMioPads-1:0]       mio_attr;
    logic [NDioPads-1:0]            dio_out;
    logic [NDioPads-1:0]            dio_oe;
  } core_pads_t;

  typedef struct packed {
    logic [GpioWidth-1:0] d2p;
    logic [GpioWidth-1:0] en;
    logic [GpioWidth-1:0] pull_en;
    logic [GpioWidth-1:0] pull_select;
  } gpio_pins_t;

  localparam int NoGpio = -1;

  // GPIO pin bit per mio pad, in mio_pad_e order
  localparam int GpioBitOf [NMioPads] = '{
    0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13,
    22, 23, 24,
    27, 30,
    NoGpio, NoGpio
  };

endpackage : chip_pkg

`default_nettype wire
